// File: Bender.yml
package:
  name: memory_game

sources:
  - include_dirs:
      - common
    files:
      - common/game_cfg_pkg.sv
      - common/game_play_pkg.sv
      - game/sequence_rom.sv
      - game/game_datapath.sv
      - game/game_control.sv
      - src/game_apb_regs.sv
      - src/game_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_clock_gen.sv
      - test/game_tb.sv

// File: common/game_cfg_pkg.sv
`default_nettype none

`include "game_defines.svh"

package game_cfg_pkg;

    // Level bits as written through CTRL[2:1]
    typedef struct packed {
        logic longGame;
        logic timed;
    } gameCfg_t;

    // Phase seen by software
    typedef enum logic [1:0] {
        IDLE,
        SHOW,
        PLAY,
        DONE
    } gamePhase_t;

    // STATUS word, low bits of prdata
    typedef struct packed {
        gamePhase_t             phase;
        // Current round minus one
        logic [`GAME_ADDR_W-1:0] round;
        logic                   won;
        logic                   lost;
    } gameStatus_t;

endpackage

`default_nettype wire

// File: common/game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Key and led word width
`define GAME_KEY_W 4

// ROM address and round counter width
`define GAME_ADDR_W 4

// Tick counter width, wide enough for the timeout
`define GAME_TICK_W 6

// Rounds per game for each level
`define GAME_SHORT_ROUNDS 4
`define GAME_LONG_ROUNDS 16

// Cycles per shown entry
`define GAME_SHOW_TICKS 8
// Idle cycles in play before a timed loss
`define GAME_TIMEOUT_TICKS 40

// APB bus widths
`define GAME_APB_ADDR_W 8
`define GAME_APB_DATA_W 32

// Register byte addresses
`define GAME_REG_CTRL 8'h00
`define GAME_REG_STATUS 8'h04

`endif

// File: common/game_play_pkg.sv
`default_nettype none

`include "game_defines.svh"

package game_play_pkg;

    // Commands from controller to datapath
    typedef struct packed {
        // Address counter
        logic clrAddr;
        logic incAddr;
        // Round counter
        logic clrRound;
        logic incRound;
        // Tick counter for show time and timeout
        logic clrTick;
        logic incTick;
        // Latch level bits
        logic loadCfg;
        // Capture key on press
        logic armKey;
        // Drive ROM entry onto led
        logic showLed;
    } dpCtrl_t;

    // Flags from datapath back to controller
    typedef struct packed {
        // Rising edge of any key
        logic                  keyPressed;
        // Registered key equals ROM entry
        logic                  keyCorrect;
        // Address has reached current round
        logic                  addrIsRound;
        // Final round of the level
        logic                  lastRound;
        // Entry held long enough
        logic                  showDone;
        logic                  timeout;
        // Latched timed level
        logic                  timed;
        logic [`GAME_KEY_W-1:0] romKey;
    } dpCond_t;

endpackage

`default_nettype wire

// File: game/game_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module game_control (
    input  wire logic                     clock,
    input  wire logic                     rst,
    input  wire logic                     start,
    input  wire game_cfg_pkg::gameCfg_t   cfg,
    input  wire game_play_pkg::dpCond_t   cond,
    output game_play_pkg::dpCtrl_t        ctrl,
    output game_cfg_pkg::gameStatus_t     status,
    output logic                          playing,
    output logic                          gameOver
);
    import game_cfg_pkg::*;

    typedef enum logic [2:0] {
        sIdle,
        sShow,
        sGap,
        sPlay,
        sJudge,
        sNextRound,
        sDone
    } ctrlState_t;

    ctrlState_t              state;
    ctrlState_t              nextState;
    logic                    toPlay;
    logic                    won;
    logic                    lost;
    logic                    setWon;
    logic                    setLost;
    logic                    accept;
    logic [`GAME_ADDR_W-1:0] round;

    // Start taken only between games
    assign accept = start && ((state == sIdle) || (state == sDone));

    always_comb begin
        nextState = state;
        ctrl      = '0;
        setWon    = 1'b0;
        setLost   = 1'b0;
        case (state)
            sIdle, sDone: begin
                // Park address at zero so the first ROM read is ready
                ctrl.clrAddr = 1'b1;
                if (accept) begin
                    ctrl.clrRound = 1'b1;
                    ctrl.clrTick  = 1'b1;
                    ctrl.loadCfg  = 1'b1;
                    nextState     = sShow;
                end
            end
            sShow: begin
                ctrl.showLed = 1'b1;
                if (cond.showDone) begin
                    ctrl.clrTick = 1'b1;
                    // Last entry of the round rewinds for play
                    if (cond.addrIsRound) begin
                        ctrl.clrAddr = 1'b1;
                    end else begin
                        ctrl.incAddr = 1'b1;
                    end
                    nextState = sGap;
                end else begin
                    ctrl.incTick = 1'b1;
                end
            end
            sGap: begin
                // Blank cycle, ROM reads the new address
                ctrl.clrTick = 1'b1;
                nextState    = toPlay ? sPlay : sShow;
            end
            sPlay: begin
                ctrl.armKey = 1'b1;
                if (cond.keyPressed) begin
                    ctrl.clrTick = 1'b1;
                    nextState    = sJudge;
                end else if (cond.timed && cond.timeout) begin
                    setLost   = 1'b1;
                    nextState = sDone;
                end else if (cond.timed) begin
                    ctrl.incTick = 1'b1;
                end
            end
            sJudge: begin
                ctrl.clrTick = 1'b1;
                if (!cond.keyCorrect) begin
                    setLost   = 1'b1;
                    nextState = sDone;
                end else if (cond.addrIsRound && cond.lastRound) begin
                    setWon    = 1'b1;
                    nextState = sDone;
                end else if (cond.addrIsRound) begin
                    // Clear early so show starts on entry zero
                    ctrl.clrAddr = 1'b1;
                    nextState    = sNextRound;
                end else begin
                    ctrl.incAddr = 1'b1;
                    nextState    = sPlay;
                end
            end
            sNextRound: begin
                ctrl.incRound = 1'b1;
                nextState     = sShow;
            end
            default: begin
                nextState = sIdle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state  <= sIdle;
            toPlay <= 1'b0;
            won    <= 1'b0;
            lost   <= 1'b0;
            round  <= '0;
        end else begin
            state <= nextState;
            // Remember whether the gap leads into play
            if (state == sShow && cond.showDone) begin
                toPlay <= cond.addrIsRound;
            end
            if (accept) begin
                won   <= 1'b0;
                lost  <= 1'b0;
                round <= '0;
            end else begin
                won  <= won || setWon;
                lost <= lost || setLost;
                if (state == sNextRound) begin
                    round <= round + 1'b1;
                end
            end
        end
    end

    // Phase as software sees it
    always_comb begin
        case (state)
            sIdle:                    status.phase = IDLE;
            sShow, sGap, sNextRound:  status.phase = SHOW;
            sPlay, sJudge:            status.phase = PLAY;
            default:                  status.phase = DONE;
        endcase
        status.round = round;
        status.won   = won;
        status.lost  = lost;
    end

    assign playing  = (status.phase == SHOW) || (status.phase == PLAY);
    assign gameOver = (state == sDone);

    // A game ends with one result only
    wonLostExclusive: assert property (
        @(posedge clock) disable iff (rst) !(won && lost)
    );

    addrNoClashCmd: assert property (
        @(posedge clock) disable iff (rst) !(ctrl.clrAddr && ctrl.incAddr)
    );

    // Datapath holds the timed level written with start
    timedLatchedAtStart: assert property (
        @(posedge clock) disable iff (rst)
        ctrl.loadCfg |=> (cond.timed == $past(cfg.timed))
    );

endmodule

`default_nettype wire

// File: game/game_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module game_datapath (
    input  wire logic                   clock,
    input  wire logic                   rst,
    input  wire logic [`GAME_KEY_W-1:0] chaves,
    input  wire game_cfg_pkg::gameCfg_t cfg,
    input  wire game_play_pkg::dpCtrl_t ctrl,
    output game_play_pkg::dpCond_t      cond,
    output logic      [`GAME_KEY_W-1:0] led
);
    import game_cfg_pkg::*;

    // Round limits for each level
    localparam logic [`GAME_ADDR_W-1:0] lastShort = `GAME_ADDR_W'(`GAME_SHORT_ROUNDS - 1);
    localparam logic [`GAME_ADDR_W-1:0] lastLong  = `GAME_ADDR_W'(`GAME_LONG_ROUNDS - 1);
    localparam logic [`GAME_TICK_W-1:0] showLimit = `GAME_TICK_W'(`GAME_SHOW_TICKS - 1);
    localparam logic [`GAME_TICK_W-1:0] timeLimit = `GAME_TICK_W'(`GAME_TIMEOUT_TICKS - 1);

    gameCfg_t               levelCfg;
    logic                   anyKey;
    logic                   anyKeyD;
    logic                   keyEdge;
    logic [`GAME_KEY_W-1:0] keyReg;
    logic [`GAME_KEY_W-1:0] romKey;
    logic [`GAME_ADDR_W-1:0] addr;
    logic [`GAME_ADDR_W-1:0] round;
    logic [`GAME_TICK_W-1:0] tick;

    // OR of the keys
    assign anyKey = |chaves;

    // Level bits held for the whole game
    always_ff @(posedge clock) begin
        if (rst) begin
            levelCfg <= '0;
        end else if (ctrl.loadCfg) begin
            levelCfg <= cfg;
        end
    end

    // Edge detector on any key
    always_ff @(posedge clock) begin
        if (rst) begin
            anyKeyD <= 1'b0;
        end else begin
            anyKeyD <= anyKey;
        end
    end

    assign keyEdge = anyKey && !anyKeyD;

    // Key register, loads on the press edge only in play
    always_ff @(posedge clock) begin
        if (rst) begin
            keyReg <= '0;
        end else if (ctrl.armKey && keyEdge) begin
            keyReg <= chaves;
        end
    end

    // Address counter, clear wins
    always_ff @(posedge clock) begin
        if (rst || ctrl.clrAddr) begin
            addr <= '0;
        end else if (ctrl.incAddr) begin
            addr <= addr + 1'b1;
        end
    end

    // Round counter holds round minus one
    always_ff @(posedge clock) begin
        if (rst || ctrl.clrRound) begin
            round <= '0;
        end else if (ctrl.incRound) begin
            round <= round + 1'b1;
        end
    end

    // Shared tick counter
    always_ff @(posedge clock) begin
        if (rst || ctrl.clrTick) begin
            tick <= '0;
        end else if (ctrl.incTick) begin
            tick <= tick + 1'b1;
        end
    end

    sequence_rom uRom (
        .clock   ( clock  ),
        .address ( addr   ),
        .data    ( romKey )
    );

    // Comparators and flags
    always_comb begin
        cond.keyPressed  = keyEdge;
        cond.keyCorrect  = (keyReg == romKey);
        cond.addrIsRound = (addr == round);
        cond.lastRound   = (round == (levelCfg.longGame ? lastLong : lastShort));
        cond.showDone    = (tick == showLimit);
        cond.timeout     = (tick == timeLimit);
        cond.timed       = levelCfg.timed;
        cond.romKey      = romKey;
    end

    // Dark unless an entry is on display
    assign led = ctrl.showLed ? romKey : '0;

endmodule

`default_nettype wire

// File: game/sequence_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module sequence_rom (
    input  wire logic                    clock,
    input  wire logic [`GAME_ADDR_W-1:0] address,
    output logic      [`GAME_KEY_W-1:0]  data
);

    // Entry i sets bit (3i+1) mod 4, so the pattern repeats every four
    always_ff @(posedge clock) begin
        case (address)
            4'd0:    data <= 4'b0010;
            4'd1:    data <= 4'b0001;
            4'd2:    data <= 4'b1000;
            4'd3:    data <= 4'b0100;
            4'd4:    data <= 4'b0010;
            4'd5:    data <= 4'b0001;
            4'd6:    data <= 4'b1000;
            4'd7:    data <= 4'b0100;
            4'd8:    data <= 4'b0010;
            4'd9:    data <= 4'b0001;
            4'd10:   data <= 4'b1000;
            4'd11:   data <= 4'b0100;
            4'd12:   data <= 4'b0010;
            4'd13:   data <= 4'b0001;
            4'd14:   data <= 4'b1000;
            4'd15:   data <= 4'b0100;
            default: data <= 4'b0010;
        endcase
    end

    // Any valid address yields a single key one cycle later
    romOneHot: assert property (
        @(posedge clock) !$isunknown(address) |=> $onehot(data)
    );

endmodule

`default_nettype wire

// File: src/game_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module game_apb_regs (
    input  wire logic                        clock,
    input  wire logic                        rst,
    input  wire logic [`GAME_APB_ADDR_W-1:0] paddr,
    input  wire logic                        psel,
    input  wire logic                        penable,
    input  wire logic                        pwrite,
    input  wire logic [`GAME_APB_DATA_W-1:0] pwdata,
    output logic      [`GAME_APB_DATA_W-1:0] prdata,
    output logic                             pready,
    output logic                             pslverr,
    input  wire game_cfg_pkg::gameStatus_t   status,
    output game_cfg_pkg::gameCfg_t           cfg,
    output logic                             start
);
    import game_cfg_pkg::*;

    logic access;
    logic isCtrl;
    logic isStatus;
    logic wrCtrl;
    logic canStart;

    // Access phase of a transfer
    assign access = psel && penable;

    // Address decode
    assign isCtrl   = (paddr == `GAME_REG_CTRL);
    assign isStatus = (paddr == `GAME_REG_STATUS);

    // Writes to STATUS are dropped silently
    assign wrCtrl = access && pwrite && isCtrl;

    // Start only from a finished or fresh game
    assign canStart = (status.phase == IDLE) || (status.phase == DONE);

    // No wait states
    assign pready = 1'b1;

    // Unmapped address
    assign pslverr = access && !(isCtrl || isStatus);

    // Level bits and one-cycle start
    always_ff @(posedge clock) begin
        if (rst) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            start <= wrCtrl && pwdata[0] && canStart;
            if (wrCtrl) begin
                cfg <= gameCfg_t'(pwdata[2:1]);
            end
        end
    end

    // Read mux, zero for anything unmapped
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (isStatus) begin
                prdata[$bits(gameStatus_t)-1:0] = status;
            end else if (isCtrl) begin
                // Level bits read back in place
                prdata[2:1] = cfg;
            end
        end
    end

    // Access phase always follows a selected setup
    apbEnableNeedsSel: assert property (
        @(posedge clock) disable iff (rst) penable |-> psel
    );

endmodule

`default_nettype wire

// File: src/game_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module game_top (
    input  wire logic                        clock,
    input  wire logic                        rst,
    input  wire logic [`GAME_APB_ADDR_W-1:0] paddr,
    input  wire logic                        psel,
    input  wire logic                        penable,
    input  wire logic                        pwrite,
    input  wire logic [`GAME_APB_DATA_W-1:0] pwdata,
    output logic      [`GAME_APB_DATA_W-1:0] prdata,
    output logic                             pready,
    output logic                             pslverr,
    input  wire logic [`GAME_KEY_W-1:0]      chaves,
    output logic      [`GAME_KEY_W-1:0]      led,
    output logic                             playing,
    output logic                             gameOver
);
    import game_cfg_pkg::*;
    import game_play_pkg::*;

    gameCfg_t    cfg;
    gameStatus_t status;
    dpCtrl_t     ctrl;
    dpCond_t     cond;
    logic        start;

    // Register block on APB
    game_apb_regs uRegs (
        .clock   ( clock   ),
        .rst     ( rst     ),
        .paddr   ( paddr   ),
        .psel    ( psel    ),
        .penable ( penable ),
        .pwrite  ( pwrite  ),
        .pwdata  ( pwdata  ),
        .prdata  ( prdata  ),
        .pready  ( pready  ),
        .pslverr ( pslverr ),
        .status  ( status  ),
        .cfg     ( cfg     ),
        .start   ( start   )
    );

    // Game FSM
    game_control uControl (
        .clock    ( clock    ),
        .rst      ( rst      ),
        .start    ( start    ),
        .cfg      ( cfg      ),
        .cond     ( cond     ),
        .ctrl     ( ctrl     ),
        .status   ( status   ),
        .playing  ( playing  ),
        .gameOver ( gameOver )
    );

    // Counters, key capture and ROM
    game_datapath uDatapath (
        .clock  ( clock  ),
        .rst    ( rst    ),
        .chaves ( chaves ),
        .cfg    ( cfg    ),
        .ctrl   ( ctrl   ),
        .cond   ( cond   ),
        .led    ( led    )
    );

endmodule

`default_nettype wire

// File: test/game_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module game_tb;
    import game_cfg_pkg::*;

    localparam int drvDelay = 10;
    // Several times the length of all tests together
    localparam int cycleLimit = 20000;
    localparam int maxPolls = 100;
    localparam int ledWaitLimit = 40;
    localparam int overWaitLimit = 100;
    localparam int timeoutMargin = 10;

    logic                        clock;
    logic                        rst;
    logic [`GAME_APB_ADDR_W-1:0] paddr;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`GAME_APB_DATA_W-1:0] pwdata;
    logic [`GAME_APB_DATA_W-1:0] prdata;
    logic                        pready;
    logic                        pslverr;
    logic [`GAME_KEY_W-1:0]      chaves;
    logic [`GAME_KEY_W-1:0]      led;
    logic                        playing;
    logic                        gameOver;

    int          valueErrors = 0;
    int          otherErrors = 0;
    int          cycles = 0;
    logic [31:0] lcgState = 32'h1824_7d18;

    tb_clock_gen uClock (
        .clock ( clock ),
        .rst   ( rst   )
    );

    game_top dut (
        .clock    ( clock    ),
        .rst      ( rst      ),
        .paddr    ( paddr    ),
        .psel     ( psel     ),
        .penable  ( penable  ),
        .pwrite   ( pwrite   ),
        .pwdata   ( pwdata   ),
        .prdata   ( prdata   ),
        .pready   ( pready   ),
        .pslverr  ( pslverr  ),
        .chaves   ( chaves   ),
        .led      ( led      ),
        .playing  ( playing  ),
        .gameOver ( gameOver )
    );

    // Watchdog on the whole run
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Run stopped: no end after %0d clock cycles", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

    // Entry i of the sequence has bit (3i+1) mod 4 set
    function automatic logic [3:0] expectedKey(input int idx);
        return 4'b0001 << ((3 * idx + 1) % 4);
    endfunction

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // One of the three one-hot keys that are not the right one
    function automatic logic [3:0] pickWrongKey(input logic [3:0] right);
        int         pick;
        int         b;
        logic [3:0] key;
        pick = int'((nextRandom() >> 16) % 3);
        key = '0;
        for (b = 0; b < 4; b++) begin
            if (!right[b]) begin
                if (pick == 0) begin
                    key = 4'b0001 << b;
                end
                pick--;
            end
        end
        return key;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        valueErrors++;
        $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    endtask

    // Setup then access cycle, sampled mid access
    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clock);
        #drvDelay;
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #drvDelay;
        penable = 1'b1;
        @(negedge clock);
        data = prdata;
        err = pslverr;
        // No wait states ever
        if (pready !== 1'b1) begin
            reportMismatch("pready on read", pready, 1);
        end
        @(posedge clock);
        #drvDelay;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clock);
        #drvDelay;
        paddr = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #drvDelay;
        penable = 1'b1;
        @(negedge clock);
        if (pslverr !== 1'b0) begin
            reportMismatch("pslverr on write", pslverr, 0);
        end
        if (pready !== 1'b1) begin
            reportMismatch("pready on write", pready, 1);
        end
        @(posedge clock);
        #drvDelay;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic readStatus(output gameStatus_t st);
        logic [31:0] data;
        logic        err;
        apbRead(`GAME_REG_STATUS, data, err);
        if (err !== 1'b0) begin
            reportMismatch("pslverr on STATUS read", err, 0);
        end
        st = gameStatus_t'(data[$bits(gameStatus_t)-1:0]);
    endtask

    // CTRL bit 2 long game, bit 1 timed, bit 0 start
    task automatic startGame(input logic longGame, input logic timed);
        apbWrite(`GAME_REG_CTRL, {29'd0, longGame, timed, 1'b1});
    endtask

    task automatic waitPhase(input gamePhase_t want);
        gameStatus_t st;
        int          polls;
        polls = 0;
        readStatus(st);
        while (st.phase !== want && polls < maxPolls) begin
            readStatus(st);
            polls++;
        end
        if (st.phase !== want) begin
            otherErrors++;
            $display("Time %0t ns: phase %0d never reached after %0d reads", $time, want, polls);
        end
    endtask

    task automatic waitGameOver();
        int n;
        n = 0;
        @(negedge clock);
        while (gameOver !== 1'b1 && n < overWaitLimit) begin
            @(negedge clock);
            n++;
        end
        if (gameOver !== 1'b1) begin
            otherErrors++;
            $display("Time %0t ns: game did not end within %0d cycles", $time, overWaitLimit);
        end
    endtask

    // Key held 3 cycles, then released 3
    task automatic pressKey(input logic [3:0] key);
        @(posedge clock);
        #drvDelay;
        chaves = key;
        repeat (3) @(posedge clock);
        #drvDelay;
        chaves = '0;
        repeat (3) @(posedge clock);
        #drvDelay;
    endtask

    // Led sampled at falling edges, one entry at a time
    task automatic checkShow(input int round);
        int i;
        int n;
        for (i = 0; i < round; i++) begin
            n = 0;
            @(negedge clock);
            while (led === '0 && n < ledWaitLimit) begin
                @(negedge clock);
                n++;
            end
            if (led !== expectedKey(i)) begin
                reportMismatch($sformatf("led round %0d entry %0d", round, i),
                               led, expectedKey(i));
            end
            n = 0;
            while (led !== '0 && n < ledWaitLimit) begin
                @(negedge clock);
                n++;
            end
            if (led !== '0) begin
                otherErrors++;
                $display("Time %0t ns: led stuck on during show", $time);
            end
        end
    endtask

    task automatic playRound(input int round);
        int i;
        waitPhase(PLAY);
        for (i = 0; i < round; i++) begin
            pressKey(expectedKey(i));
        end
    endtask

    task automatic checkFinal(input logic expWon, input logic expLost, input int expRound,
                              input string tag);
        gameStatus_t st;
        waitGameOver();
        readStatus(st);
        if (st.phase !== DONE) begin
            reportMismatch({tag, " phase"}, st.phase, DONE);
        end
        if (st.won !== expWon) begin
            reportMismatch({tag, " won"}, st.won, expWon);
        end
        if (st.lost !== expLost) begin
            reportMismatch({tag, " lost"}, st.lost, expLost);
        end
        if (st.round !== expRound[3:0]) begin
            reportMismatch({tag, " round"}, st.round, expRound);
        end
        if (playing !== 1'b0) begin
            reportMismatch({tag, " playing"}, playing, 0);
        end
    endtask

    task automatic resetState();
        gameStatus_t st;
        gameStatus_t again;
        logic [31:0] data;
        logic        err;
        readStatus(st);
        // IDLE, round 0, no result
        if (st !== '0) begin
            reportMismatch("STATUS after reset", st, 0);
        end
        if (playing !== 1'b0 || gameOver !== 1'b0 || led !== '0) begin
            reportMismatch("outputs after reset", {playing, gameOver, led}, 0);
        end
        apbRead(8'h08, data, err);
        if (err !== 1'b1) begin
            reportMismatch("pslverr on 0x8", err, 1);
        end
        if (data !== '0) begin
            reportMismatch("prdata on 0x8", data, 0);
        end
        readStatus(again);
        if (again !== st) begin
            reportMismatch("STATUS after bad access", again, st);
        end
    endtask

    task automatic sequenceOnLed();
        int r;
        startGame(1'b0, 1'b0);
        for (r = 1; r <= `GAME_SHORT_ROUNDS; r++) begin
            checkShow(r);
            playRound(r);
        end
        waitGameOver();
    endtask

    task automatic shortGameWin();
        int r;
        startGame(1'b0, 1'b0);
        for (r = 1; r <= `GAME_SHORT_ROUNDS; r++) begin
            playRound(r);
        end
        checkFinal(1'b1, 1'b0, `GAME_SHORT_ROUNDS - 1, "short win");
    endtask

    task automatic wrongKeyLoses();
        startGame(1'b0, 1'b0);
        playRound(1);
        waitPhase(PLAY);
        pressKey(pickWrongKey(expectedKey(0)));
        checkFinal(1'b0, 1'b1, 1, "wrong key");
    endtask

    task automatic idleTimeout();
        gameStatus_t st;
        startGame(1'b0, 1'b1);
        waitPhase(PLAY);
        // Still playing well before the limit
        repeat (`GAME_TIMEOUT_TICKS - timeoutMargin) @(posedge clock);
        @(negedge clock);
        if (playing !== 1'b1) begin
            reportMismatch("timed game before limit", playing, 1);
        end
        repeat (2 * timeoutMargin) @(posedge clock);
        checkFinal(1'b0, 1'b1, 0, "timed wait");
        // Untimed game ignores the wait
        startGame(1'b0, 1'b0);
        waitPhase(PLAY);
        repeat (`GAME_TIMEOUT_TICKS + timeoutMargin) @(posedge clock);
        readStatus(st);
        if (st.phase !== PLAY || st.lost !== 1'b0) begin
            reportMismatch("untimed wait phase and lost", {st.phase, st.lost}, {PLAY, 1'b0});
        end
        pressKey(pickWrongKey(expectedKey(0)));
        checkFinal(1'b0, 1'b1, 0, "untimed end");
    endtask

    task automatic longGameWin();
        gameStatus_t st;
        int          r;
        startGame(1'b1, 1'b0);
        for (r = 1; r <= `GAME_LONG_ROUNDS; r++) begin
            if (r == 3) begin
                // Start in the middle of play is dropped
                waitPhase(PLAY);
                startGame(1'b1, 1'b0);
                readStatus(st);
                if (st.phase !== PLAY || st.round !== 4'd2) begin
                    reportMismatch("start during play", {st.phase, st.round}, {PLAY, 4'd2});
                end
            end
            playRound(r);
        end
        checkFinal(1'b1, 1'b0, `GAME_LONG_ROUNDS - 1, "long win");
    endtask

    initial begin
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        chaves = '0;
        wait (rst === 1'b0);
        resetState();
        sequenceOnLed();
        shortGameWin();
        wrongKeyLoses();
        idleTimeout();
        longGameWin();
        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Reset over the first 8 rising edges, released like any other input
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clock);
        #10;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/game_cfg_pkg.sv
common/game_play_pkg.sv
game/sequence_rom.sv
game/game_datapath.sv
game/game_control.sv
src/game_apb_regs.sv
src/game_top.sv
test/tb_clock_gen.sv
test/game_tb.sv
